/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := execPort_tb
FILELIST  := sources.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS      := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* divider.sv */
`include "execPort_cfg.svh"

module divider import opPkg::*, wbPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  Opcode op,
    input  Word   srcA,
    input  Word   srcB,
    input  Tag    dst,
    input  SqN    sqN,
    input  logic  flushValid,
    input  SqN    flushSqN,
    input  logic  wbFree,
    output logic  busy,
    output logic  resValid,
    output Tag    resDst,
    output Word   resData,
    output SqN    resSqN
);

    DivState                          state;
    logic [$clog2(`DIV_STEPS)-1:0]    step;
    logic                             lastStep;
    logic                             kill;
    logic                             signedOp;
    logic                             isRem;
    logic                             negQuo;
    logic                             negRem;
    logic                             divZero;
    Word                              absA;
    Word                              absB;
    Word                              quo;
    Word                              rem;
    Word                              dvs;
    Word                              quoOut;
    Word                              remOut;
    logic [`DATA_W:0]                 shifted;
    logic [`DATA_W:0]                 diff;

    assign signedOp = (op == opDiv) || (op == opRem);
    assign absA = (signedOp && srcA[`DATA_W-1]) ? Word'(-srcA) : srcA;
    assign absB = (signedOp && srcB[`DATA_W-1]) ? Word'(-srcB) : srcB;

    // Each restoring step shifts in the next dividend bit and tries to subtract.
    assign shifted = {rem, quo[`DATA_W-1]};
    assign diff = shifted - {1'b0, dvs};

    assign lastStep = (step == ($clog2(`DIV_STEPS))'(`DIV_STEPS - 1));
    assign kill = flushValid && (state != divIdle) && isYounger(resSqN, flushSqN);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= divIdle;
            step  <= '0;
        end else if (en) begin
            state <= divRun;
            step  <= '0;
        end else if (kill) begin
            state <= divIdle;
        end else begin
            case (state)
                divRun: begin
                    step <= step + 1'b1;
                    if (lastStep) begin
                        state <= divDone;
                    end
                end
                divDone: begin
                    if (wbFree) begin
                        state <= divIdle; // Result taken this cycle.
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rem     <= '0;
            quo     <= absA;
            dvs     <= absB;
            isRem   <= (op == opRem) || (op == opRemu);
            divZero <= (srcB == '0);
            negQuo  <= signedOp && (srcA[`DATA_W-1] ^ srcB[`DATA_W-1]);
            negRem  <= signedOp && srcA[`DATA_W-1];
            resDst  <= dst;
            resSqN  <= sqN;
        end else if (state == divRun) begin
            rem <= diff[`DATA_W] ? shifted[`DATA_W-1:0] : diff[`DATA_W-1:0];
            quo <= {quo[`DATA_W-2:0], !diff[`DATA_W]};
        end
    end

    // Division by zero leaves the dividend magnitude in rem, so only the
    // quotient needs the override. The signed overflow case falls out as is.
    assign quoOut = divZero ? '1 : (negQuo ? Word'(-quo) : quo);
    assign remOut = negRem ? Word'(-rem) : rem;

    assign resData  = isRem ? remOut : quoOut;
    assign resValid = (state == divDone) && !kill;
    assign busy     = (state != divIdle);

endmodule

/* execPort.sv */
`include "execPort_cfg.svh"

module execPort import opPkg::*, wbPkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          issueValid,
    input  Opcode                         issueOp,
    input  logic [$clog2(`NUM_REGS)-1:0]  issueSrcA,
    input  logic [$clog2(`NUM_REGS)-1:0]  issueSrcB,
    input  Word                           issueImm,
    input  Tag                            issueDst,
    input  SqN                            issueSqN,
    input  logic                          flushValid,
    input  SqN                            flushSqN,
    output logic                          wbValid,
    output Tag                            wbDst,
    output Word                           wbResult,
    output SqN                            wbSqN,
    output logic                          divBlocked
);

    FuType issueFu;
    Word   srcA;
    Word   srcB;
    logic  aluValid;
    Tag    aluDst;
    Word   aluData;
    SqN    aluSqN;
    logic  divBusy;
    logic  divValid;
    Tag    divDst;
    Word   divData;
    SqN    divSqN;

    assign issueFu = (issueOp inside {opDiv, opDivu, opRem, opRemu}) ? fuDiv : fuInt;

    regFile rf (
        .clk    (clk),
        .we     (wbValid && !wbDst[`TAG_W-1]), // No-result tags skip the write.
        .waddr  (wbDst[$clog2(`NUM_REGS)-1:0]),
        .wdata  (wbResult),
        .raddrA (issueSrcA),
        .raddrB (issueSrcB),
        .rdataA (srcA),
        .rdataB (srcB)
    );

    intAlu ialu (
        .clk        (clk),
        .reset      (reset),
        .en         (issueValid && issueFu == fuInt),
        .op         (issueOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .imm        (issueImm),
        .dst        (issueDst),
        .sqN        (issueSqN),
        .flushValid (flushValid),
        .flushSqN   (flushSqN),
        .resValid   (aluValid),
        .resDst     (aluDst),
        .resData    (aluData),
        .resSqN     (aluSqN)
    );

    divider div (
        .clk        (clk),
        .reset      (reset),
        .en         (issueValid && issueFu == fuDiv),
        .op         (issueOp),
        .srcA       (srcA),
        .srcB       (srcB),
        .dst        (issueDst),
        .sqN        (issueSqN),
        .flushValid (flushValid),
        .flushSqN   (flushSqN),
        .wbFree     (!aluValid), // ALU owns the slot whenever it has a result.
        .busy       (divBusy),
        .resValid   (divValid),
        .resDst     (divDst),
        .resData    (divData),
        .resSqN     (divSqN)
    );

    assign wbValid    = aluValid || divValid;
    assign wbDst      = aluValid ? aluDst : divDst;
    assign wbResult   = aluValid ? aluData : divData;
    assign wbSqN      = aluValid ? aluSqN : divSqN;
    assign divBlocked = divBusy;

endmodule

/* execPort_asserts.sv */
`include "execPort_cfg.svh"

module execPort_asserts import opPkg::*; (
    input logic  clk,
    input logic  reset,
    input logic  issueValid,
    input Opcode issueOp,
    input SqN    issueSqN,
    input logic  flushValid,
    input SqN    flushSqN,
    input logic  wbValid,
    input SqN    wbSqN,
    input logic  divBlocked
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failCount = 0;
    logic divIssue;
    logic aluIssue;

    function automatic logic younger(SqN a, SqN b);
        SqN d;
        d = a - b;
        return (d != '0) && !d[`SQN_W-1];
    endfunction

    assign divIssue = issueValid && (issueOp inside {opDiv, opDivu, opRem, opRemu});
    assign aluIssue = issueValid && !divIssue;

    quietAfterReset: assert property (@(posedge clk) reset |=> !wbValid && !divBlocked)
        else begin
            failCount++;
            $error("wbValid or divBlocked high in the cycle after reset");
        end

    // Only a flush in the writeback cycle may hide an ALU result.
    aluLatency: assert property (@(posedge clk) disable iff (reset)
        aluIssue |=> (wbValid && wbSqN == $past(issueSqN))
            || (flushValid && younger($past(issueSqN), flushSqN)))
        else begin
            failCount++;
            $error("ALU operation did not write back one cycle after issue");
        end

    divAccept: assert property (@(posedge clk) disable iff (reset) !(divIssue && divBlocked))
        else begin
            failCount++;
            $error("Divide issued while divBlocked was high");
        end

    divBlockRise: assert property (@(posedge clk) disable iff (reset) divIssue |=> divBlocked)
        else begin
            failCount++;
            $error("divBlocked did not rise after a divide was accepted");
        end

    divBlockHold: assert property (@(posedge clk) disable iff (reset)
        $fell(divBlocked) |-> $past(wbValid) || $past(flushValid))
        else begin
            failCount++;
            $error("divBlocked fell without a writeback or flush in the cycle before");
        end

    flushSameCycle: assert property (@(posedge clk) disable iff (reset)
        flushValid |-> !(wbValid && younger(wbSqN, flushSqN)))
        else begin
            failCount++;
            $error("Writeback of an operation younger than a flush in the same cycle");
        end

    flushKill: assert property (@(posedge clk) disable iff (reset)
        flushValid |=> !(wbValid && younger(wbSqN, $past(flushSqN))))
        else begin
            failCount++;
            $error("Writeback of an operation younger than the previous flush");
        end

endmodule

/* execPort_cfg.svh */
`ifndef EXECPORT_CFG_SVH
`define EXECPORT_CFG_SVH

// Operand and result width.
`define DATA_W 32

// Destination tag. The top bit marks an operation without a result,
// the remaining bits select a physical register.
`define TAG_W 7

`define NUM_REGS 64

// Sequence numbers wrap, so age is judged by signed difference.
`define SQN_W 7

// One restoring step per result bit.
`define DIV_STEPS 32

`endif

/* execPort_tb.sv */
`include "execPort_cfg.svh"

module execPort_tb import opPkg::*, wbPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int regAw = $clog2(`NUM_REGS);
    localparam int depth = 1 << `SQN_W;
    localparam int randAluOps = 200;
    localparam int randDivOps = 16;
    localparam int burstLen = `DIV_STEPS + 4; // Outlasts the divide, so its finish meets the ALU.
    localparam int opCount = `NUM_REGS + randAluOps + 31 + randDivOps + 2 * burstLen + 10;
    localparam int cycleLimit = opCount * (`DIV_STEPS + 4) + 100;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    logic             issueValid = 1'b0;
    Opcode            issueOp = opAdd;
    logic [regAw-1:0] issueSrcA = '0;
    logic [regAw-1:0] issueSrcB = '0;
    Word              issueImm = '0;
    Tag               issueDst = '0;
    SqN               issueSqN = '0;
    logic             flushValid = 1'b0;
    SqN               flushSqN = '0;
    logic             wbValid;
    Tag               wbDst;
    Word              wbResult;
    SqN               wbSqN;
    logic             divBlocked;

    logic [31:0]      rngState = 32'h96a6;
    Word              model [`NUM_REGS];
    logic             pendValid [depth] = '{default: 1'b0};
    Tag               pendDst [depth];
    Word              pendData [depth];
    int               pendCount = 0;
    SqN               nextSqN = '0;
    int               mismatches = 0;
    int               otherErrors = 0;

    // Divide operands for r1 to r7, and the register pairs that use them.
    Word              divVals [7] = '{32'd100, 32'd7, 32'hffff_ff9c, 32'd0, 32'h8000_0000,
                                      32'hffff_ffff, 32'h5a5a_1234};
    logic [regAw-1:0] pairA [6] = '{6'd1, 6'd3, 6'd1, 6'd3, 6'd5, 6'd7};
    logic [regAw-1:0] pairB [6] = '{6'd2, 6'd2, 6'd4, 6'd4, 6'd6, 6'd3};

    execPort dut (.*);

    bind execPort execPort_asserts checks (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    function automatic logic younger(SqN a, SqN b);
        SqN d;
        d = a - b;
        return (d != '0) && !d[`SQN_W-1]; // Positive wraparound distance.
    endfunction

    function automatic Word modelResult(Opcode op, Word a, Word b, Word imm);
        logic ovf;
        ovf = (a == 32'h8000_0000) && (b == '1);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSll:   return a << b[4:0];
            opSrl:   return a >> b[4:0];
            opSra:   return Word'($signed(a) >>> b[4:0]);
            opSlt:   return Word'($signed(a) < $signed(b));
            opSltu:  return Word'(a < b);
            opMovi:  return imm;
            opDiv:   return (b == '0) ? '1 : (ovf ? a : Word'($signed(a) / $signed(b)));
            opDivu:  return (b == '0) ? '1 : a / b;
            opRem:   return (b == '0) ? a : (ovf ? '0 : Word'($signed(a) % $signed(b)));
            opRemu:  return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    task automatic issue(Opcode op, logic [regAw-1:0] a, logic [regAw-1:0] b, Word imm, Tag dst);
        @(negedge clk);
        issueValid = 1'b1;
        flushValid = 1'b0;
        issueOp = op;
        issueSrcA = a;
        issueSrcB = b;
        issueImm = imm;
        issueDst = dst;
        issueSqN = nextSqN;
        pendValid[nextSqN] = 1'b1;
        pendDst[nextSqN] = dst;
        pendData[nextSqN] = modelResult(op, model[a], model[b], imm);
        pendCount++;
        nextSqN++;
    endtask

    task automatic flush(SqN older);
        @(negedge clk);
        issueValid = 1'b0;
        flushValid = 1'b1;
        flushSqN = older;
        for (int i = 0; i < depth; i++) begin
            if (pendValid[i] && younger(SqN'(i), older)) begin
                pendValid[i] = 1'b0;
                pendCount--;
            end
        end
    endtask

    // Idles until every expected writeback has arrived and the divider is free.
    task automatic drain();
        do begin
            @(negedge clk);
            issueValid = 1'b0;
            flushValid = 1'b0;
        end while (pendCount != 0 || divBlocked);
    endtask

    always @(posedge clk) begin
        if (!reset && wbValid) begin
            if (!pendValid[wbSqN]) begin
                otherErrors++;
                $display("Writeback at %0t has sequence number %0d with nothing in flight",
                         $time, wbSqN);
            end else begin
                if (wbDst !== pendDst[wbSqN]) begin
                    mismatches++;
                    $display("Mismatch at %0t: wbDst is %h, expected %h",
                             $time, wbDst, pendDst[wbSqN]);
                end
                if (wbResult !== pendData[wbSqN]) begin
                    mismatches++;
                    $display("Mismatch at %0t: wbResult is %h, expected %h",
                             $time, wbResult, pendData[wbSqN]);
                end
                if (!pendDst[wbSqN][`TAG_W-1]) begin
                    model[pendDst[wbSqN][regAw-1:0]] = pendData[wbSqN];
                end
                pendValid[wbSqN] = 1'b0;
                pendCount--;
            end
        end
    end

    initial begin
        repeat (cycleLimit) @(posedge clk);
        $display("Timeout: the run did not end within %0d cycles", cycleLimit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        SqN  s;
        Word v;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < `NUM_REGS; i++) begin
            issue(opMovi, '0, '0, xorshift(), Tag'(i));
        end
        drain();
        for (int i = 0; i < randAluOps; i++) begin
            v = xorshift();
            issue(Opcode'(4'(v % 10)), regAw'(xorshift()), regAw'(xorshift()), '0,
                  {v[31:29] == 3'b0, regAw'(xorshift())}); // Some tags carry no result.
        end
        drain();

        for (int i = 0; i < 7; i++) begin
            issue(opMovi, '0, '0, divVals[i], Tag'(i + 1));
        end
        drain();
        for (int k = 0; k < 4; k++) begin
            for (int p = 0; p < 6; p++) begin
                issue(Opcode'(4'(int'(opDiv) + k)), pairA[p], pairB[p], '0, Tag'(8 + 6 * k + p));
                drain();
            end
        end
        for (int i = 0; i < randDivOps; i++) begin
            issue(Opcode'(4'(int'(opDiv) + xorshift() % 4)), regAw'(xorshift()),
                  regAw'(xorshift()), '0, {1'b0, regAw'(xorshift())});
            drain();
        end

        issue(opDivu, regAw'(xorshift()), regAw'(xorshift()), '0, {1'b0, regAw'(xorshift())});
        for (int i = 0; i < burstLen; i++) begin
            issue(Opcode'(4'(xorshift() % 10)), regAw'(xorshift()), regAw'(xorshift()), '0,
                  {1'b0, regAw'(xorshift())});
        end
        drain();

        s = nextSqN;
        issue(opDiv, 6'd1, 6'd2, '0, 7'd40);
        for (int i = 0; i < burstLen; i++) begin
            issue(opAnd, 6'd1, 6'd2, '0, 7'h40); // Keeps the finished divide waiting.
        end
        flush(s - 1'b1);
        drain();
        s = nextSqN;
        issue(opAdd, 6'd1, 6'd2, '0, 7'd41);
        flush(s - 1'b1);
        drain();
        s = nextSqN;
        issue(opRem, 6'd3, 6'd2, '0, 7'd42); // Older than the flush point, so it survives.
        issue(opSub, 6'd1, 6'd2, '0, 7'd43);
        flush(s);
        drain();
        s = nextSqN;
        issue(opOr, 6'd1, 6'd2, '0, 7'd44);
        flush(s);
        drain();

        issue(opMovi, '0, '0, 32'h1234_5678, 7'd20);
        issue(opAdd, 6'd1, 6'd2, '0, {1'b1, 6'd20});
        drain();
        issue(opDivu, 6'd1, 6'd2, '0, {1'b1, 6'd20});
        drain();
        issue(opOr, 6'd20, 6'd20, '0, 7'd21); // Reads back r20 through a real write.
        drain();

        $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, otherErrors, dut.checks.failCount);
        if (mismatches + otherErrors + dut.checks.failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* intAlu.sv */
`include "execPort_cfg.svh"

module intAlu import opPkg::*, wbPkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  en,
    input  Opcode op,
    input  Word   srcA,
    input  Word   srcB,
    input  Word   imm,
    input  Tag    dst,
    input  SqN    sqN,
    input  logic  flushValid,
    input  SqN    flushSqN,
    output logic  resValid,
    output Tag    resDst,
    output Word   resData,
    output SqN    resSqN
);

    logic       held;
    logic [4:0] shamt;
    Word        result;

    assign shamt = srcB[4:0];

    always_comb begin
        case (op)
            opAdd:   result = srcA + srcB;
            opSub:   result = srcA - srcB;
            opAnd:   result = srcA & srcB;
            opOr:    result = srcA | srcB;
            opXor:   result = srcA ^ srcB;
            opSll:   result = srcA << shamt;
            opSrl:   result = srcA >> shamt;
            opSra:   result = $signed(srcA) >>> shamt;
            opSlt:   result = Word'($signed(srcA) < $signed(srcB));
            opSltu:  result = Word'(srcA < srcB);
            opMovi:  result = imm;
            default: result = '0; // Divider opcodes never reach here.
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else begin
            held <= en; // The result lives for exactly one cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            resDst  <= dst;
            resData <= result;
            resSqN  <= sqN;
        end
    end

    // A flush in the writeback cycle still cancels a younger result.
    assign resValid = held && !(flushValid && isYounger(resSqN, flushSqN));

endmodule

/* opPkg.sv */
`include "execPort_cfg.svh"

package opPkg;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSll,
        opSrl,
        opSra,
        opSlt,
        opSltu,
        opMovi,
        opDiv,
        opDivu,
        opRem,
        opRemu
    } Opcode;

    typedef enum logic {
        fuInt,
        fuDiv
    } FuType;

    typedef logic [`TAG_W-1:0] Tag;
    typedef logic [`SQN_W-1:0] SqN;

    // True when a was issued after b.
    function automatic logic isYounger(SqN a, SqN b);
        return $signed(SqN'(a - b)) > 0;
    endfunction

endpackage

/* regFile.sv */
`include "execPort_cfg.svh"

module regFile import wbPkg::*; (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(`NUM_REGS)-1:0]  waddr,
    input  Word                           wdata,
    input  logic [$clog2(`NUM_REGS)-1:0]  raddrA,
    input  logic [$clog2(`NUM_REGS)-1:0]  raddrB,
    output Word                           rdataA,
    output Word                           rdataB
);

    Word regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Reads are combinational, so a value written at an edge is
    // visible to an issue in the very next cycle.
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

endmodule

/* sources.f */
+incdir+.
opPkg.sv
wbPkg.sv
regFile.sv
intAlu.sv
divider.sv
execPort.sv
execPort_asserts.sv
execPort_tb.sv

/* wbPkg.sv */
`include "execPort_cfg.svh"

package wbPkg;

    // divDone holds the result until the writeback slot is free.
    typedef enum logic [1:0] {
        divIdle,
        divRun,
        divDone
    } DivState;

    typedef logic [`DATA_W-1:0] Word;

endpackage
